/* verilog/spi_cmd_pkg.sv */
package spi_cmd_pkg;

    // ========================================================================
    // Word and field widths
    // ========================================================================
    localparam int unsigned word_width  = 16;
    localparam int unsigned id_width    = 3;
    localparam int unsigned num_targets = 8;
    localparam int unsigned addr_width  = 8;

    // Command word layout, bits 15..14 and bit 0 stay zero
    localparam int unsigned cmd_id_lsb     = 11;
    localparam int unsigned cmd_addr_lsb   = 3;
    localparam int unsigned cmd_global_bit = 2;
    localparam int unsigned cmd_read_bit   = 1;

    // Target descriptor on the switches, address sits in the low byte
    localparam int unsigned sw_global_bit = 15;
    localparam int unsigned sw_id_lsb     = 8;

    // ========================================================================
    // Timing
    // ========================================================================
    // System clocks per half SCLK period
    localparam int unsigned sclk_half_div = 8;
    // Bits in each half of a frame
    localparam int unsigned frame_bits    = 16;

    // Board defaults at 100 MHz
    localparam int unsigned default_debounce_cycles = 250_000;
    localparam int unsigned default_hold_cycles     = 300_000_000;

    // ========================================================================
    // Opcodes and states
    // ========================================================================
    typedef enum logic {
        spi_op_write = 1'b0,
        spi_op_read  = 1'b1
    } spi_op_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_latch,
        seq_await,
        seq_start,
        seq_wait,
        seq_hold
    } seq_state_t;

    typedef enum logic [2:0] {
        spi_idle,
        spi_send_cmd,
        spi_prep_data,
        spi_data,
        spi_done
    } spi_state_t;

endpackage

/* verilog/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce import spi_cmd_pkg::*; #(
    parameter int unsigned debounce_cycles = default_debounce_cycles
) (
    input  logic clk,
    input  logic sys_reset,
    input  logic btn,
    output logic level
);

    logic        sync0;
    logic        sync1;
    logic [31:0] count;

    // Two-flop synchronizer for the raw button
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            sync0 <= 1'b0;
            sync1 <= 1'b0;
        end else begin
            sync0 <= btn;
            sync1 <= sync0;
        end
    end

    // The synchronized value must differ from the stable level for more
    // than debounce_cycles clocks before the level follows it
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            count <= 32'd0;
            level <= 1'b0;
        end else if (sync1 != level) begin
            if (count >= debounce_cycles) begin
                level <= sync1;
                count <= 32'd0;
            end else begin
                count <= count + 32'd1;
            end
        end else begin
            // Bounce back to the old level restarts the count
            count <= 32'd0;
        end
    end

endmodule

/* verilog/hold_timer.sv */
`timescale 1ns/1ps

module hold_timer import spi_cmd_pkg::*; #(
    parameter int unsigned hold_cycles = default_hold_cycles
) (
    input  logic clk,
    input  logic sys_reset,
    input  logic start,
    output logic done
);

    logic        running;
    logic [31:0] count;

    // One-shot, a start while running is dropped
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            running <= 1'b0;
            count   <= 32'd0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !running) begin
                running <= 1'b1;
                count   <= 32'd0;
            end else if (running) begin
                count <= count + 32'd1;
                if (count == hold_cycles - 1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/command_sequencer.sv */
`timescale 1ns/1ps

module command_sequencer import spi_cmd_pkg::*; (
    input  logic                  clk,
    input  logic                  sys_reset,
    input  logic                  latch_level,
    input  logic                  write_level,
    input  logic                  read_level,
    input  logic [word_width-1:0] sw,
    input  logic                  tx_ready,
    input  logic                  rx_done,
    input  logic [word_width-1:0] rx_data,
    input  logic                  timer_done,
    output logic                  tx_valid,
    output logic [word_width-1:0] tx_cmd,
    output logic [word_width-1:0] tx_data,
    output logic                  timer_start,
    output logic [word_width-1:0] led,
    output logic                  red_led,
    output logic                  green_led,
    output logic                  blue_led,
    output logic                  write_led
);

    seq_state_t state;

    logic latch_q;
    logic write_q;
    logic read_q;
    logic latch_edge;
    logic write_edge;
    logic read_edge;

    // Latched target descriptor
    logic                  lat_global;
    logic [id_width-1:0]   lat_id;
    logic [addr_width-1:0] lat_addr;

    spi_op_t             op;
    logic                gw_mode;
    logic [id_width-1:0] gw_id;

    function automatic logic [word_width-1:0] build_cmd(
        input logic [id_width-1:0]   id,
        input logic [addr_width-1:0] addr,
        input logic                  global_flag,
        input spi_op_t               cmd_op
    );
        logic [word_width-1:0] cmd;
        cmd = '0;
        cmd[cmd_id_lsb +: id_width]     = id;
        cmd[cmd_addr_lsb +: addr_width] = addr;
        cmd[cmd_global_bit]             = global_flag;
        cmd[cmd_read_bit]               = (cmd_op == spi_op_read);
        return cmd;
    endfunction

    // One press gives one operation
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            latch_q <= 1'b0;
            write_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            latch_q <= latch_level;
            write_q <= write_level;
            read_q  <= read_level;
        end
    end

    assign latch_edge = latch_level && !latch_q;
    assign write_edge = write_level && !write_q;
    assign read_edge  = read_level && !read_q;

    // ========================================================================
    // Operation FSM
    // ========================================================================
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            state       <= seq_idle;
            lat_global  <= 1'b0;
            lat_id      <= '0;
            lat_addr    <= '0;
            op          <= spi_op_write;
            gw_mode     <= 1'b0;
            gw_id       <= '0;
            tx_valid    <= 1'b0;
            tx_cmd      <= '0;
            tx_data     <= '0;
            timer_start <= 1'b0;
            led         <= '0;
            red_led     <= 1'b0;
            green_led   <= 1'b0;
            blue_led    <= 1'b0;
            write_led   <= 1'b0;
        end else begin
            timer_start <= 1'b0;

            case (state)
                seq_idle, seq_await: begin
                    if (latch_edge) begin
                        lat_global <= sw[sw_global_bit];
                        lat_id     <= sw[sw_id_lsb +: id_width];
                        lat_addr   <= sw[addr_width-1:0];
                        red_led    <= 1'b1;
                        green_led  <= 1'b0;
                        state      <= seq_latch;
                    end else if (write_edge) begin
                        op       <= spi_op_write;
                        tx_data  <= sw;
                        blue_led <= 1'b1;
                        gw_mode  <= lat_global;
                        gw_id    <= '0;
                        // Global writes start at target 0
                        if (lat_global) begin
                            tx_cmd <= build_cmd('0, lat_addr, 1'b1, spi_op_write);
                        end else begin
                            tx_cmd <= build_cmd(lat_id, lat_addr, 1'b0, spi_op_write);
                        end
                        state <= seq_start;
                    end else if (read_edge) begin
                        // Reads always address one target
                        op      <= spi_op_read;
                        gw_mode <= 1'b0;
                        tx_data <= '0;
                        tx_cmd  <= build_cmd(lat_id, lat_addr, 1'b0, spi_op_read);
                        state   <= seq_start;
                    end
                end

                // Red flashes for one cycle on a latch
                seq_latch: begin
                    red_led <= 1'b0;
                    state   <= seq_await;
                end

                // Valid drops in the cycle after the transfer
                seq_start: begin
                    if (tx_valid && tx_ready) begin
                        tx_valid <= 1'b0;
                        state    <= seq_wait;
                    end else begin
                        tx_valid <= 1'b1;
                    end
                end

                seq_wait: begin
                    if (rx_done) begin
                        if (op == spi_op_read) begin
                            led       <= rx_data;
                            red_led   <= (rx_data == '0);
                            green_led <= (rx_data != '0);
                            state     <= seq_await;
                        end else if (gw_mode && gw_id != id_width'(num_targets - 1)) begin
                            gw_id  <= gw_id + 1'b1;
                            tx_cmd <= build_cmd(gw_id + 1'b1, lat_addr, 1'b1, spi_op_write);
                            state  <= seq_start;
                        end else begin
                            write_led   <= 1'b1;
                            timer_start <= 1'b1;
                            state       <= seq_hold;
                        end
                    end
                end

                // Write lamps stay lit until the hold timer expires
                seq_hold: begin
                    if (timer_done) begin
                        blue_led  <= 1'b0;
                        write_led <= 1'b0;
                        state     <= seq_await;
                    end
                end

                default: state <= seq_idle;
            endcase
        end
    end

endmodule

/* verilog/spi_master.sv */
`timescale 1ns/1ps

module spi_master import spi_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   sys_reset,
    input  logic                   tx_valid,
    input  logic [word_width-1:0]  tx_cmd,
    input  logic [word_width-1:0]  tx_data,
    input  logic                   miso,
    output logic                   tx_ready,
    output logic                   rx_done,
    output logic [word_width-1:0]  rx_data,
    output logic                   sclk,
    output logic                   mosi,
    output logic [num_targets-1:0] cs_n
);

    localparam int unsigned div_width = $clog2(sclk_half_div);

    spi_state_t state;

    logic                  active;
    logic [div_width-1:0]  div_cnt;
    logic                  tick;
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic [5:0]            bit_cnt;
    logic [word_width-1:0] shift_out;
    logic [word_width-1:0] rx_shift;
    logic [word_width-1:0] cmd_q;
    logic [word_width-1:0] data_q;
    logic [id_width-1:0]   frame_id;
    spi_op_t               frame_op;

    assign tx_ready = (state == spi_idle);

    // Decode from the stored command
    assign frame_id = cmd_q[cmd_id_lsb +: id_width];
    assign frame_op = spi_op_t'(cmd_q[cmd_read_bit]);
    assign cs_n     = active ? ~(num_targets'(1) << frame_id) : '1;

    // ========================================================================
    // SCLK divider, mode 0 so idle low
    // ========================================================================
    assign tick      = active && (div_cnt == '0);
    assign sclk_rise = tick && !sclk;
    assign sclk_fall = tick && sclk;

    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            div_cnt <= div_width'(sclk_half_div - 1);
            sclk    <= 1'b0;
        end else if (active) begin
            if (div_cnt == '0) begin
                div_cnt <= div_width'(sclk_half_div - 1);
                sclk    <= ~sclk;
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
        end else begin
            div_cnt <= div_width'(sclk_half_div - 1);
            sclk    <= 1'b0;
        end
    end

    // Frame payload and returned data
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            cmd_q  <= tx_cmd;
            data_q <= tx_data;
        end
        if (state == spi_data && sclk_rise) begin
            rx_shift <= {rx_shift[word_width-2:0], miso};
        end
        if (state == spi_done && frame_op == spi_op_read) begin
            rx_data <= rx_shift;
        end
    end

    // ========================================================================
    // Shift engine, bit_cnt counts rising SCLK edges over the frame
    // ========================================================================
    always_ff @(posedge clk or posedge sys_reset) begin
        if (sys_reset) begin
            state     <= spi_idle;
            active    <= 1'b0;
            bit_cnt   <= 6'd0;
            shift_out <= '0;
            mosi      <= 1'b0;
            rx_done   <= 1'b0;
        end else begin
            rx_done <= 1'b0;

            case (state)
                spi_idle: begin
                    if (tx_valid) begin
                        active    <= 1'b1;
                        bit_cnt   <= 6'd0;
                        shift_out <= tx_cmd;
                        mosi      <= tx_cmd[word_width-1];
                        state     <= spi_send_cmd;
                    end
                end

                spi_send_cmd: begin
                    if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                    if (sclk_fall) begin
                        if (bit_cnt == 6'(frame_bits)) begin
                            state <= spi_prep_data;
                        end else begin
                            shift_out <= {shift_out[word_width-2:0], 1'b0};
                            mosi      <= shift_out[word_width-2];
                        end
                    end
                end

                // SCLK has just fallen, so mosi may change here
                spi_prep_data: begin
                    if (frame_op == spi_op_read) begin
                        shift_out <= '0;
                        mosi      <= 1'b0;
                    end else begin
                        shift_out <= data_q;
                        mosi      <= data_q[word_width-1];
                    end
                    state <= spi_data;
                end

                spi_data: begin
                    if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                    if (sclk_fall) begin
                        if (bit_cnt == 6'(2 * frame_bits)) begin
                            active <= 1'b0;
                            mosi   <= 1'b0;
                            state  <= spi_done;
                        end else begin
                            shift_out <= {shift_out[word_width-2:0], 1'b0};
                            mosi      <= shift_out[word_width-2];
                        end
                    end
                end

                spi_done: begin
                    rx_done <= 1'b1;
                    state   <= spi_idle;
                end

                default: state <= spi_idle;
            endcase
        end
    end

endmodule

/* verilog/master_top.sv */
`timescale 1ns/1ps

module master_top import spi_cmd_pkg::*; #(
    parameter int unsigned debounce_cycles = default_debounce_cycles,
    parameter int unsigned hold_cycles     = default_hold_cycles
) (
    input  logic                   clk,
    input  logic                   sys_reset,
    input  logic [word_width-1:0]  sw,
    input  logic                   btn_latch,
    input  logic                   btn_write,
    input  logic                   btn_read,
    input  logic                   spi_miso,
    output logic [word_width-1:0]  led,
    output logic [2:0]             rgb,
    output logic                   write_led,
    output logic                   spi_sclk,
    output logic                   spi_mosi,
    output logic [num_targets-1:0] spi_cs_n
);

    logic                  latch_level;
    logic                  write_level;
    logic                  read_level;
    logic                  timer_start;
    logic                  timer_done;
    logic                  tx_valid;
    logic                  tx_ready;
    logic [word_width-1:0] tx_cmd;
    logic [word_width-1:0] tx_data;
    logic                  rx_done;
    logic [word_width-1:0] rx_data;

    // ========================================================================
    // Button conditioning
    // ========================================================================
    button_debounce #(.debounce_cycles(debounce_cycles)) u_db_latch (
        .clk       (clk),
        .sys_reset (sys_reset),
        .btn       (btn_latch),
        .level     (latch_level)
    );

    button_debounce #(.debounce_cycles(debounce_cycles)) u_db_write (
        .clk       (clk),
        .sys_reset (sys_reset),
        .btn       (btn_write),
        .level     (write_level)
    );

    button_debounce #(.debounce_cycles(debounce_cycles)) u_db_read (
        .clk       (clk),
        .sys_reset (sys_reset),
        .btn       (btn_read),
        .level     (read_level)
    );

    hold_timer #(.hold_cycles(hold_cycles)) u_timer (
        .clk       (clk),
        .sys_reset (sys_reset),
        .start     (timer_start),
        .done      (timer_done)
    );

    // ========================================================================
    // Sequencer and SPI engine
    // ========================================================================
    // rgb is red, green, blue from bit 0 up
    command_sequencer u_sequencer (
        .clk         (clk),
        .sys_reset   (sys_reset),
        .latch_level (latch_level),
        .write_level (write_level),
        .read_level  (read_level),
        .sw          (sw),
        .tx_ready    (tx_ready),
        .rx_done     (rx_done),
        .rx_data     (rx_data),
        .timer_done  (timer_done),
        .tx_valid    (tx_valid),
        .tx_cmd      (tx_cmd),
        .tx_data     (tx_data),
        .timer_start (timer_start),
        .led         (led),
        .red_led     (rgb[0]),
        .green_led   (rgb[1]),
        .blue_led    (rgb[2]),
        .write_led   (write_led)
    );

    spi_master u_spi (
        .clk       (clk),
        .sys_reset (sys_reset),
        .tx_valid  (tx_valid),
        .tx_cmd    (tx_cmd),
        .tx_data   (tx_data),
        .miso      (spi_miso),
        .tx_ready  (tx_ready),
        .rx_done   (rx_done),
        .rx_data   (rx_data),
        .sclk      (spi_sclk),
        .mosi      (spi_mosi),
        .cs_n      (spi_cs_n)
    );

endmodule

/* verification/tb_master_top.sv */
`timescale 1ns/1ps

module tb_master_top import spi_cmd_pkg::*; ();

    localparam int tb_debounce  = 4;
    localparam int tb_hold      = 200;
    localparam int clk_period   = 100;
    localparam int press_latch  = 0;
    localparam int press_write  = 1;
    localparam int press_read   = 2;

    logic                   clk;
    logic                   sys_reset;
    logic [word_width-1:0]  sw;
    logic                   btn_latch;
    logic                   btn_write;
    logic                   btn_read;
    logic                   spi_miso;
    logic [word_width-1:0]  led;
    logic [2:0]             rgb;
    logic                   write_led;
    logic                   spi_sclk;
    logic                   spi_mosi;
    logic [num_targets-1:0] spi_cs_n;

    int seed = 32'h0be5_785b;

    // SPI target model state
    logic [31:0]            rx_bits;
    int                     bit_count = 0;
    logic [num_targets-1:0] cur_cs;
    logic                   cur_cs_ok;
    logic [15:0]            resp_word = 16'h0000;
    logic [31:0]            frame_q[$];
    logic [num_targets-1:0] cs_q[$];
    logic                   cs_ok_q[$];

    master_top #(
        .debounce_cycles (tb_debounce),
        .hold_cycles     (tb_hold)
    ) u_dut (
        .clk       (clk),
        .sys_reset (sys_reset),
        .sw        (sw),
        .btn_latch (btn_latch),
        .btn_write (btn_write),
        .btn_read  (btn_read),
        .spi_miso  (spi_miso),
        .led       (led),
        .rgb       (rgb),
        .write_led (write_led),
        .spi_sclk  (spi_sclk),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic logic [15:0] expected_cmd(input logic [2:0] id, input logic [7:0] addr,
                                                 input logic global_flag, input logic read);
        return {2'b00, id, addr, global_flag, read, 1'b0};
    endfunction

    // Every eighth address of a target answers zero
    function automatic logic [15:0] expected_read(input logic [2:0] id, input logic [7:0] addr);
        logic [15:0] h;
        h = {addr, addr ^ 8'h5a} ^ ({13'h0, id} * 16'h2f1d);
        if (addr[2:0] == id) begin
            h = 16'h0000;
        end
        return h;
    endfunction

    // ========================================================================
    // SPI target, records mosi and answers reads on miso
    // ========================================================================
    always @(posedge spi_sclk) begin
        if (spi_cs_n !== '1) begin
            if (bit_count == 0) begin
                cur_cs    = spi_cs_n;
                cur_cs_ok = 1'b1;
            end else if (spi_cs_n !== cur_cs) begin
                cur_cs_ok = 1'b0;
            end
            rx_bits   = {rx_bits[30:0], spi_mosi};
            bit_count = bit_count + 1;
            if (bit_count == 16) begin
                if (rx_bits[1]) begin
                    resp_word = expected_read(rx_bits[13:11], rx_bits[10:3]);
                end else begin
                    resp_word = 16'h0000;
                end
            end
            if (bit_count == 32) begin
                frame_q.push_back(rx_bits);
                cs_q.push_back(cur_cs);
                cs_ok_q.push_back(cur_cs_ok);
                bit_count = 0;
            end
        end
    end

    // Response bit is stable before the next rising edge
    always @(negedge spi_sclk) begin
        if (bit_count >= 16) begin
            spi_miso = resp_word[31 - bit_count];
        end else begin
            spi_miso = 1'b0;
        end
    end

    // ========================================================================
    // Checks and bounded waits
    // ========================================================================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("TB FAILED");
        $fatal(1, "Timeout");
    endtask

    task automatic wait_frames(input int count, input int limit, input string what);
        int n;
        n = 0;
        while (frame_q.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (frame_q.size() < count) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_read_lamp(input int limit);
        int n;
        n = 0;
        while (!(rgb[0] || rgb[1]) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(rgb[0] || rgb[1])) begin
            report_timeout("the red or green lamp after a read");
        end
    endtask

    task automatic wait_write_led(input int limit);
        int n;
        n = 0;
        while (write_led !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (write_led !== 1'b1) begin
            report_timeout("write_led to rise after a write");
        end
    endtask

    task automatic wait_lamps_dark(input int limit);
        int n;
        n = 0;
        while ((rgb[2] || write_led) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rgb[2] || write_led) begin
            report_timeout("the write lamps to go dark");
        end
    endtask

    // ========================================================================
    // Stimulus, driven on falling edges
    // ========================================================================
    task automatic press_button(input int which);
        @(negedge clk);
        case (which)
            press_latch: btn_latch = 1'b1;
            press_write: btn_write = 1'b1;
            default:     btn_read  = 1'b1;
        endcase
        repeat (20) @(negedge clk);
        btn_latch = 1'b0;
        btn_write = 1'b0;
        btn_read  = 1'b0;
        repeat (20) @(negedge clk);
    endtask

    // Bits 14..11 of the switches carry junk that the DUT must ignore
    task automatic latch_target(input logic global_flag, input logic [2:0] id,
                                input logic [7:0] addr, input logic [3:0] junk);
        @(negedge clk);
        sw = {global_flag, junk, id, addr};
        press_button(press_latch);
    endtask

    task automatic check_frame(input int index, input logic [2:0] id, input logic [7:0] addr,
                               input logic global_flag, input logic read,
                               input logic [15:0] data, input logic check_data);
        logic [num_targets-1:0] cs_exp;
        int                     b;
        // Only the chip select of the addressed target is low
        for (b = 0; b < num_targets; b++) begin
            cs_exp[b] = (b != id);
        end
        check_value("frame command", frame_q[index][31:16],
                    expected_cmd(id, addr, global_flag, read));
        check_value("spi_cs_n", cs_q[index], cs_exp);
        check_value("spi_cs_n stable", cs_ok_q[index], 1'b1);
        if (check_data) begin
            check_value("frame data", frame_q[index][15:0], data);
        end
    endtask

    task automatic run_read(input logic [2:0] id, input logic [7:0] addr);
        logic [31:0] rnd;
        logic [15:0] exp;
        int          base;
        rnd = $random(seed);
        latch_target(1'b0, id, addr, rnd[3:0]);
        base = frame_q.size();
        press_button(press_read);
        wait_frames(base + 1, 1500, "a read frame");
        wait_read_lamp(50);
        check_value("frame count", frame_q.size(), base + 1);
        check_frame(base, id, addr, 1'b0, 1'b1, 16'h0000, 1'b0);
        exp = expected_read(id, addr);
        check_value("led", led, exp);
        check_value("rgb red", rgb[0], exp == 16'h0000);
        check_value("rgb green", rgb[1], exp != 16'h0000);
    endtask

    task automatic run_write(input logic global_flag, input logic [2:0] id,
                             input logic [7:0] addr, input logic [15:0] data);
        logic [31:0] rnd;
        int          base;
        int          k;
        rnd = $random(seed);
        latch_target(global_flag, id, addr, rnd[3:0]);
        @(negedge clk);
        sw = data;
        base = frame_q.size();
        press_button(press_write);
        wait_write_led(global_flag ? 6000 : 1500);
        if (global_flag) begin
            check_value("frame count", frame_q.size(), base + num_targets);
            for (k = 0; k < num_targets; k++) begin
                check_frame(base + k, 3'(k), addr, 1'b1, 1'b0, data, 1'b1);
            end
        end else begin
            check_value("frame count", frame_q.size(), base + 1);
            check_frame(base, id, addr, 1'b0, 1'b0, data, 1'b1);
        end
        check_value("rgb blue", rgb[2], 1'b1);
    endtask

    // Lamps stay lit for the hold time, then clear
    task automatic check_hold();
        repeat (tb_hold / 2) @(negedge clk);
        check_value("rgb blue", rgb[2], 1'b1);
        check_value("write_led", write_led, 1'b1);
        wait_lamps_dark(tb_hold / 2 + 50);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        logic [31:0] rnd;
        logic [7:0]  addr;
        int          i;

        sys_reset = 1'b1;
        sw        = '0;
        btn_latch = 1'b0;
        btn_write = 1'b0;
        btn_read  = 1'b0;
        spi_miso  = 1'b0;
        repeat (16) @(negedge clk);
        sys_reset = 1'b0;
        @(negedge clk);

        check_value("spi_cs_n", spi_cs_n, {num_targets{1'b1}});
        check_value("spi_sclk", spi_sclk, 1'b0);
        check_value("spi_mosi", spi_mosi, 1'b0);
        check_value("led", led, 16'h0000);
        check_value("rgb", rgb, 3'b000);
        check_value("write_led", write_led, 1'b0);

        // The first read hits an address that answers zero
        for (i = 0; i < 6; i++) begin
            rnd  = $random(seed);
            addr = rnd[15:8];
            if (i == 0) begin
                addr[2:0] = rnd[2:0];
            end
            run_read(rnd[2:0], addr);
        end

        rnd = $random(seed);
        run_write(1'b0, rnd[2:0], rnd[15:8], rnd[31:16]);
        check_hold();

        rnd = $random(seed);
        run_write(1'b1, rnd[2:0], rnd[15:8], rnd[31:16]);
        check_hold();

        rnd = $random(seed);
        run_read(rnd[2:0], rnd[15:8]);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* files.f */
verilog/spi_cmd_pkg.sv
verilog/button_debounce.sv
verilog/hold_timer.sv
verilog/command_sequencer.sv
verilog/spi_master.sv
verilog/master_top.sv
verification/tb_master_top.sv

/* Bender.yml */
package:
  name: spi_cmd_master

sources:
  - verilog/spi_cmd_pkg.sv
  - verilog/button_debounce.sv
  - verilog/hold_timer.sv
  - verilog/command_sequencer.sv
  - verilog/spi_master.sv
  - verilog/master_top.sv
  - target: test
    files:
      - verification/tb_master_top.sv
